// ==== Bender.yml ====
package:
  name: nes_control

sources:
  - files:
      - logic/nes_io_pkg.sv
      - logic/host_reg_decoder.sv
      - logic/joypad_shifter.sv
      - logic/nes_phase_seq.sv
      - logic/nes_control_top.sv
  - target: test
    files:
      - bench/nes_control_tb.sv

// ==== bench/nes_control_tb.sv ====
//********************
// testbench for the console board host-control logic
// drives host writes, controller reads and hold changes
// a cycle model predicts every output, checked on each rising edge
//********************

module nes_control_tb;

  localparam int CLK_PERIOD = 40;
  localparam int N_DATA     = 24;  // OSD bytes in the random stream
  localparam int N_UNMAPPED = 4;
  localparam int N_WRAP     = 6;   // bytes written across the 4096 wrap
  localparam int PAD_STEPS  = 40;
  localparam int FRAME_IDLE = 36;
  localparam int HOLD_IDLE  = 18;
  localparam int N_WRITES   = 3 + N_DATA + N_UNMAPPED + 2 + N_WRAP
                            + 2 * nes_io_pkg::NUM_PADS + 2;
  // two clocks per host write plus the idle stretches
  localparam int PLANNED_CYCLES = 2 + 2 * N_WRITES + PAD_STEPS + 12
                                + 2 * FRAME_IDLE + HOLD_IDLE + 4;

  logic                            clk = 1'b0;
  logic                            reset;
  nes_io_pkg::host_write_t         host;
  logic                            pad_strobe;
  logic [nes_io_pkg::NUM_PADS-1:0] pad_clock;
  logic [nes_io_pkg::NUM_PADS-1:0] pad_data;
  nes_io_pkg::osd_port_t           osd;
  logic                            run_mem;
  logic                            run_nes;
  logic                            nes_reset;

  integer seed = 51;
  int     errors = 0;
  int     checks = 0;
  string  test_name = "reset";

  // model state, as the DUT registers hold it before the current edge
  nes_io_pkg::byte_t        m_conf;
  nes_io_pkg::pad_buttons_t m_buttons [nes_io_pkg::NUM_PADS];
  nes_io_pkg::pad_buttons_t m_load    [nes_io_pkg::NUM_PADS];  // byte taken at strobe
  int                       m_shifts  [nes_io_pkg::NUM_PADS];
  logic                     m_pclk_q  [nes_io_pkg::NUM_PADS];
  nes_io_pkg::osd_addr_t    m_osd_addr;
  logic                     m_osd_en;
  nes_io_pkg::phase_t       m_phase;    // free running, like the sequencer
  logic                     m_run_mem;
  logic                     m_run_nes;
  logic                     m_nes_reset;
  int                       since_mem;  // cycles since the last run_mem
  logic                     frame_ok;

  nes_control_top nes_control_top_inst (
    .clk        (clk),
    .reset      (reset),
    .host       (host),
    .pad_strobe (pad_strobe),
    .pad_clock  (pad_clock),
    .pad_data   (pad_data),
    .osd        (osd),
    .run_mem    (run_mem),
    .run_nes    (run_nes),
    .nes_reset  (nes_reset)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    #((PLANNED_CYCLES + 200) * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", PLANNED_CYCLES + 200);
    $display("ERRORS FOUND");
    $finish;
  end

  // serial bit after a number of shifts, zeros come in from the top
  function automatic logic expected_pad_bit(nes_io_pkg::pad_buttons_t buttons, int shifts);
    nes_io_pkg::pad_buttons_t rest;
    if (shifts >= nes_io_pkg::PAD_BITS)
      return 1'b0;
    rest = buttons >> shifts;
    return rest[0];
  endfunction

  task automatic compare_value(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else begin
      errors++;
      $display("[ERROR] %s %s expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  // frame spacing seen on the outputs alone
  task automatic check_frame();
    since_mem++;
    checks++;
    assert (!(run_mem && run_nes))
    else begin
      errors++;
      $display("in test %s run_mem and run_nes were high in the same cycle", test_name);
    end
    if (run_mem) begin
      if (frame_ok)
        compare_value("run_mem spacing", nes_io_pkg::NES_PHASES, since_mem);
      since_mem = 0;
      frame_ok  = 1'b1;
    end
    if (run_nes && frame_ok)
      compare_value("run_nes offset", nes_io_pkg::NES_PHASE - nes_io_pkg::MEM_PHASE, since_mem);
    if (m_conf[0])
      frame_ok = 1'b0;  // spacing restarts after a hold
  endtask

  task automatic advance_model();
    // the sequencer sees the hold from before this edge's write
    m_run_mem   = (m_phase == nes_io_pkg::MEM_PHASE) && !m_conf[0];
    m_run_nes   = (m_phase == nes_io_pkg::NES_PHASE) && !m_conf[0];
    m_nes_reset = m_conf[0];
    m_phase     = (m_phase == nes_io_pkg::NES_PHASES - 1) ? '0 : m_phase + 1'b1;
    for (int i = 0; i < nes_io_pkg::NUM_PADS; i++) begin
      if (pad_strobe) begin
        m_load[i]   = m_buttons[i];
        m_shifts[i] = 0;
      end else if (m_pclk_q[i] && !pad_clock[i]) begin
        m_shifts[i]++;
      end
      m_pclk_q[i] = pad_clock[i];
    end
    if (host.valid) begin
      case (host.addr)
        nes_io_pkg::REG_LOADER_CONF: m_conf = host.data;
        nes_io_pkg::REG_PAD0:        m_buttons[0] = host.data;
        nes_io_pkg::REG_PAD1:        m_buttons[1] = host.data;
        nes_io_pkg::REG_OSD_ADDR_LO: m_osd_addr[7:0] = host.data;
        nes_io_pkg::REG_OSD_ADDR_HI: m_osd_addr[11:8] = host.data[3:0];
        nes_io_pkg::REG_OSD_DATA:    m_osd_addr = m_osd_addr + 1'b1;  // wraps at 4096
        nes_io_pkg::REG_OSD_ENABLE:  m_osd_en = host.data[0];
        default: ;
      endcase
    end
  endtask

  always @(posedge clk) begin : compare_outputs
    logic exp_we;
    if (reset) begin
      m_conf      = '0;
      m_osd_addr  = '0;
      m_osd_en    = 1'b0;
      m_phase     = '0;
      m_run_mem   = 1'b0;
      m_run_nes   = 1'b0;
      m_nes_reset = 1'b0;
      since_mem   = 0;
      frame_ok    = 1'b0;
      for (int i = 0; i < nes_io_pkg::NUM_PADS; i++) begin
        m_buttons[i] = '0;
        m_load[i]    = '0;
        m_shifts[i]  = 0;
        m_pclk_q[i]  = 1'b0;
      end
    end else begin
      exp_we = host.valid && (host.addr == nes_io_pkg::REG_OSD_DATA);
      compare_value("osd.enable", m_osd_en, osd.enable);
      compare_value("osd.addr", m_osd_addr, osd.addr);
      compare_value("osd.we", exp_we, osd.we);
      if (exp_we)
        compare_value("osd.din", host.data, osd.din);
      for (int i = 0; i < nes_io_pkg::NUM_PADS; i++)
        compare_value($sformatf("pad_data[%0d]", i),
                      expected_pad_bit(m_load[i], m_shifts[i]), pad_data[i]);
      compare_value("run_mem", m_run_mem, run_mem);
      compare_value("run_nes", m_run_nes, run_nes);
      compare_value("nes_reset", m_nes_reset, nes_reset);
      check_frame();
      advance_model();
    end
  end

  task automatic host_write(nes_io_pkg::reg_addr_t addr, nes_io_pkg::byte_t data);
    @(negedge clk);
    host.addr  = addr;
    host.data  = data;
    host.valid = 1'b1;
    @(negedge clk);
    host.valid = 1'b0;  // one-cycle strobe
  endtask

  task automatic idle_cycles(int n);
    repeat (n) @(negedge clk);
  endtask

  initial begin : stimulus
    nes_io_pkg::byte_t     lo;
    nes_io_pkg::byte_t     hi;
    nes_io_pkg::byte_t     en;
    nes_io_pkg::reg_addr_t unmapped [N_UNMAPPED];
    unmapped   = '{8'h00, 8'h36, 8'h42, 8'h84};
    reset      = 1'b1;
    host       = '0;
    pad_strobe = 1'b0;
    pad_clock  = '0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    test_name = "osd_setup";
    lo = nes_io_pkg::byte_t'($random(seed));
    hi = nes_io_pkg::byte_t'($random(seed));
    en = nes_io_pkg::byte_t'($random(seed)) | 8'h01;  // enable leaves its reset value
    host_write(nes_io_pkg::REG_OSD_ADDR_LO, lo);
    host_write(nes_io_pkg::REG_OSD_ADDR_HI, hi);
    host_write(nes_io_pkg::REG_OSD_ENABLE, en);
    compare_value("osd.addr after setup", {hi[3:0], lo}, osd.addr);
    compare_value("osd.enable after setup", en[0], osd.enable);

    test_name = "osd_stream";
    for (int n = 0; n < N_DATA; n++) begin
      host_write(nes_io_pkg::REG_OSD_DATA, nes_io_pkg::byte_t'($random(seed)));
      if (n % (N_DATA / N_UNMAPPED) == 0)  // stray writes that must change nothing
        host_write(unmapped[n / (N_DATA / N_UNMAPPED)], nes_io_pkg::byte_t'($random(seed)));
    end
    host_write(nes_io_pkg::REG_OSD_ADDR_LO, 8'hfc);  // four bytes below the top
    host_write(nes_io_pkg::REG_OSD_ADDR_HI, 8'hff);
    for (int n = 0; n < N_WRAP; n++)
      host_write(nes_io_pkg::REG_OSD_DATA, nes_io_pkg::byte_t'($random(seed)));

    test_name = "pad_read";
    for (int p = 0; p < nes_io_pkg::NUM_PADS; p++)
      host_write(nes_io_pkg::reg_addr_t'(nes_io_pkg::REG_PAD0 + p),
                 nes_io_pkg::byte_t'($random(seed)));
    @(negedge clk);
    pad_strobe = 1'b1;
    @(negedge clk);
    pad_strobe = 1'b0;
    for (int s = 0; s < PAD_STEPS; s++) begin
      @(negedge clk);
      pad_clock[0] = (s < PAD_STEPS / 2) && s[0];  // fast clock, then quiet
      pad_clock[1] = s[1];                         // half the rate
    end
    @(negedge clk);
    pad_clock = '0;
    idle_cycles(2);

    // a clock fall in the strobe cycle must not shift
    for (int p = 0; p < nes_io_pkg::NUM_PADS; p++)
      host_write(nes_io_pkg::reg_addr_t'(nes_io_pkg::REG_PAD0 + p),
                 nes_io_pkg::byte_t'($random(seed)) | 8'h01);  // first bit out is set
    pad_clock = '1;
    @(negedge clk);
    pad_clock  = '0;
    pad_strobe = 1'b1;
    @(negedge clk);
    pad_strobe = 1'b0;
    idle_cycles(2);

    test_name = "phase_frame";
    idle_cycles(FRAME_IDLE);

    test_name = "console_hold";
    host_write(nes_io_pkg::REG_LOADER_CONF, nes_io_pkg::byte_t'($random(seed)) | 8'h01);
    idle_cycles(HOLD_IDLE);
    compare_value("nes_reset while held", 1'b1, nes_reset);
    host_write(nes_io_pkg::REG_LOADER_CONF, nes_io_pkg::byte_t'($random(seed)) & 8'hfe);
    idle_cycles(FRAME_IDLE);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== logic/host_reg_decoder.sv ====
//********************
// host register decoder
// turns one-cycle host writes into loader config, button bytes and OSD controls
// OSD data strobe is passed through combinationally in the write cycle
//********************

module host_reg_decoder (
  input  logic                                              clk,
  input  logic                                              reset,
  input  nes_io_pkg::host_write_t                           host,
  output nes_io_pkg::pad_buttons_t [nes_io_pkg::NUM_PADS-1:0] buttons,
  output logic                                              nes_hold,
  output nes_io_pkg::osd_port_t                             osd
);

  nes_io_pkg::byte_t                                 loader_conf_q;
  nes_io_pkg::pad_buttons_t [nes_io_pkg::NUM_PADS-1:0] buttons_q;
  nes_io_pkg::osd_addr_t                             osd_addr_q;
  logic                                              osd_enable_q;

  // write decode
  logic                            wr_loader;
  logic                            wr_addr_lo;
  logic                            wr_addr_hi;
  logic                            wr_data;
  logic                            wr_enable;
  logic [nes_io_pkg::NUM_PADS-1:0] wr_pad;

  assign wr_loader  = host.valid && (host.addr == nes_io_pkg::REG_LOADER_CONF);
  assign wr_addr_lo = host.valid && (host.addr == nes_io_pkg::REG_OSD_ADDR_LO);
  assign wr_addr_hi = host.valid && (host.addr == nes_io_pkg::REG_OSD_ADDR_HI);
  assign wr_data    = host.valid && (host.addr == nes_io_pkg::REG_OSD_DATA);
  assign wr_enable  = host.valid && (host.addr == nes_io_pkg::REG_OSD_ENABLE);

  // pad registers sit at consecutive addresses from REG_PAD0
  always_comb begin
    for (int i = 0; i < nes_io_pkg::NUM_PADS; i++) begin
      wr_pad[i] = host.valid &&
                  (host.addr == nes_io_pkg::reg_addr_t'(nes_io_pkg::REG_PAD0 + i));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      loader_conf_q <= '0;
      osd_enable_q  <= 1'b0;
      osd_addr_q    <= '0;
    end else begin
      if (wr_loader)
        loader_conf_q <= host.data;
      if (wr_enable)
        osd_enable_q <= host.data[0];

      // at most one of these per cycle, one address per write
      if (wr_addr_lo)
        osd_addr_q[7:0] <= host.data;
      else if (wr_addr_hi)
        osd_addr_q[11:8] <= host.data[3:0];  // upper nibble only
      else if (wr_data)
        osd_addr_q <= osd_addr_q + 1'b1;     // wraps at 4096
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      buttons_q <= '0;  // all released
    end else begin
      for (int i = 0; i < nes_io_pkg::NUM_PADS; i++) begin
        if (wr_pad[i])
          buttons_q[i] <= host.data;
      end
    end
  end

  assign buttons  = buttons_q;
  assign nes_hold = loader_conf_q[0];

  // display port, strobe and data straight from the host write
  assign osd.enable = osd_enable_q;
  assign osd.we     = wr_data;
  assign osd.addr   = osd_addr_q;
  assign osd.din    = host.data;

  // each data byte moves the OSD pointer by exactly one
  a_addr_advances: assert property (
    @(posedge clk) disable iff (reset)
    osd.we |=> (osd.addr == nes_io_pkg::osd_addr_t'($past(osd.addr) + 1'b1))
  );

endmodule

// ==== logic/joypad_shifter.sv ====
//********************
// one controller port, parallel in and serial out
// loads the button byte while strobe is high, shifts on pad clock falls
//********************

module joypad_shifter (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     strobe,
  input  logic                     pad_clock,
  input  nes_io_pkg::pad_buttons_t buttons,
  output logic                     pad_data
);

  nes_io_pkg::pad_buttons_t shift_q;
  logic                     pad_clock_q;  // previous pad clock level
  logic                     pad_fall;
  logic [3:0]               shift_cnt;    // shifts since last load, stops at 8

  assign pad_fall = pad_clock_q && !pad_clock;

  always_ff @(posedge clk) begin
    if (reset) begin
      shift_q     <= '0;
      pad_clock_q <= 1'b0;
      shift_cnt   <= '0;
    end else begin
      pad_clock_q <= pad_clock;
      if (strobe) begin  // strobe wins over a shift
        shift_q   <= buttons;
        shift_cnt <= '0;
      end else if (pad_fall) begin
        shift_q <= {1'b0, shift_q[nes_io_pkg::PAD_BITS-1:1]};  // zeros fill from the top
        if (shift_cnt != 4'(nes_io_pkg::PAD_BITS))
          shift_cnt <= shift_cnt + 1'b1;
      end
    end
  end

  assign pad_data = shift_q[0];

  // a fully drained register reads as released
  a_drained_reads_zero: assert property (
    @(posedge clk) disable iff (reset)
    (shift_cnt == 4'(nes_io_pkg::PAD_BITS)) |-> !pad_data
  );

endmodule

// ==== logic/nes_control_top.sv ====
//********************
// host-control side of the console board
// host register decoder, controller shifters and the frame sequencer
//********************

module nes_control_top (
  input  logic                            clk,
  input  logic                            reset,
  input  nes_io_pkg::host_write_t         host,
  input  logic                            pad_strobe,
  input  logic [nes_io_pkg::NUM_PADS-1:0] pad_clock,
  output logic [nes_io_pkg::NUM_PADS-1:0] pad_data,
  output nes_io_pkg::osd_port_t           osd,
  output logic                            run_mem,
  output logic                            run_nes,
  output logic                            nes_reset
);

  nes_io_pkg::pad_buttons_t [nes_io_pkg::NUM_PADS-1:0] pad_buttons;  // decoder to shifters
  logic                                              nes_hold;

  host_reg_decoder host_reg_decoder_inst (
    .clk      (clk),
    .reset    (reset),
    .host     (host),
    .buttons  (pad_buttons),
    .nes_hold (nes_hold),
    .osd      (osd)
  );

  // one shifter per controller port
  // serial bits go straight out as on the console bus
  for (genvar i = 0; i < nes_io_pkg::NUM_PADS; i++) begin : g_pad
    joypad_shifter joypad_shifter_inst (
      .clk       (clk),
      .reset     (reset),
      .strobe    (pad_strobe),     // shared by both ports
      .pad_clock (pad_clock[i]),
      .buttons   (pad_buttons[i]),
      .pad_data  (pad_data[i])
    );
  end

  nes_phase_seq nes_phase_seq_inst (
    .clk       (clk),
    .reset     (reset),
    .nes_hold  (nes_hold),
    .run_mem   (run_mem),
    .run_nes   (run_nes),
    .nes_reset (nes_reset)
  );

endmodule

// ==== logic/nes_io_pkg.sv ====
//********************
// shared types and constants for the console board host-control logic
// register map of the host channel, controller and OSD widths, frame slots
// referenced by scoped name from every RTL file and the bench
//********************

package nes_io_pkg;

  // widths that carry a meaning
  typedef logic [7:0]  reg_addr_t;     // host register address
  typedef logic [7:0]  byte_t;
  typedef logic [11:0] osd_addr_t;     // 4 KB OSD memory
  typedef logic [7:0]  pad_buttons_t;  // bit 0 goes out first
  typedef logic [2:0]  phase_t;

  // one write on the host channel, valid for a single cycle
  typedef struct packed {
    reg_addr_t addr;
    byte_t     data;
    logic      valid;
  } host_write_t;

  // toward the display block
  typedef struct packed {
    logic      enable;
    logic      we;      // one-cycle data strobe
    osd_addr_t addr;
    byte_t     din;
  } osd_port_t;

  // host register map
  localparam reg_addr_t REG_LOADER_CONF = 8'h35;  // bit 0 holds the console in reset
  localparam reg_addr_t REG_PAD0        = 8'h40;
  localparam reg_addr_t REG_PAD1        = 8'h41;
  localparam reg_addr_t REG_OSD_ADDR_LO = 8'h80;
  localparam reg_addr_t REG_OSD_ADDR_HI = 8'h81;  // only bits 3..0 used
  localparam reg_addr_t REG_OSD_DATA    = 8'h82;  // address advances after each byte
  localparam reg_addr_t REG_OSD_ENABLE  = 8'h83;

  // controller ports
  localparam int NUM_PADS = 2;
  localparam int PAD_BITS = $bits(pad_buttons_t);

  // six-slot frame
  // slot 0 feeds the memory side, slot 5 steps the console
  localparam int     NES_PHASES = 6;
  localparam phase_t MEM_PHASE  = 3'd0;
  localparam phase_t NES_PHASE  = 3'd5;

endpackage

// ==== logic/nes_phase_seq.sv ====
//********************
// six-slot frame sequencer
// shares one clock between a memory slot and a console step slot
// grants are held off while the console sits in reset
//********************

module nes_phase_seq (
  input  logic clk,
  input  logic reset,
  input  logic nes_hold,
  output logic run_mem,
  output logic run_nes,
  output logic nes_reset
);

  nes_io_pkg::phase_t phase_q;
  logic               last_phase;
  logic               run_mem_q;
  logic               run_nes_q;
  logic               nes_reset_q;

  assign last_phase = (phase_q == nes_io_pkg::phase_t'(nes_io_pkg::NES_PHASES - 1));

  always_ff @(posedge clk) begin
    if (reset)
      phase_q <= '0;
    else if (last_phase)
      phase_q <= '0;
    else
      phase_q <= phase_q + 1'b1;
  end

  // grants registered off the count
  // so run_mem shows in the first cycle after reset and run_nes 5 clocks on
  always_ff @(posedge clk) begin
    if (reset) begin
      run_mem_q   <= 1'b0;
      run_nes_q   <= 1'b0;
      nes_reset_q <= 1'b0;
    end else begin
      run_mem_q   <= (phase_q == nes_io_pkg::MEM_PHASE) && !nes_hold;
      run_nes_q   <= (phase_q == nes_io_pkg::NES_PHASE) && !nes_hold;
      nes_reset_q <= nes_hold;  // lines up with the grants dropping
    end
  end

  assign run_mem   = run_mem_q;
  assign run_nes   = run_nes_q;
  assign nes_reset = nes_reset_q;

  // memory and console never own the same slot
  a_grants_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    !(run_mem && run_nes)
  );

  // console slot five clocks after each memory slot unless held
  a_nes_after_mem: assert property (
    @(posedge clk) disable iff (reset)
    run_mem |-> ##(nes_io_pkg::NES_PHASE - nes_io_pkg::MEM_PHASE) (run_nes || nes_reset)
  );

endmodule

// ==== nes_control_top.f ====
logic/nes_io_pkg.sv
logic/host_reg_decoder.sv
logic/joypad_shifter.sv
logic/nes_phase_seq.sv
logic/nes_control_top.sv
bench/nes_control_tb.sv
